//--- test/pointerUnit_trace.txt
# gap kind mode operand index addr carry indirect; operand, index and addr in hex
# kind L load, C calc, B load and calc on one edge; gap 1 allows random idle cycles first
0 C 0 00 5a 005a 0 0
0 C 1 00 13 0013 0 0
0 L 0 34 00 0000 0 0
0 L 0 12 00 0000 0 0
0 C 1 00 05 0017 0 0
0 C 2 00 f0 0102 0 1
0 C 5 00 01 0035 0 0
0 C 4 00 10 1244 0 0
0 L 0 ff 00 0000 0 0
0 L 0 ff 00 0000 0 0
0 C 4 00 01 0000 1 0
0 C 4 00 80 007f 1 0
0 L 0 20 00 0000 0 0
0 C 3 00 05 ff25 0 0
0 C 3 00 e0 0000 1 0
0 C 6 00 44 2044 0 0
0 B 1 81 02 0022 0 0
0 C 6 00 00 8100 0 0
0 B 4 7e 03 8123 0 0
0 B 5 01 10 0091 0 0
0 C 4 00 ff 027d 0 0
0 C 2 00 ff 0100 0 1
0 C 0 00 00 0000 0 0
1 L 0 c3 00 0000 0 0
1 C 3 00 3c ffff 0 0
1 C 3 00 3d 0000 1 0
1 C 4 00 00 c301 0 0
1 C 6 00 ff c3ff 0 0
1 C 5 00 01 0002 0 0
1 B 2 55 0a 00cd 0 1
1 C 4 00 00 55c3 0 0

//--- pointerUnit.f
+incdir+verilog
verilog/pointerPkg.sv
verilog/operandLatch.sv
verilog/addrModeDecode.sv
verilog/aluInputMux.sv
verilog/pointerAlu.sv
verilog/pointerUnit.sv
test/pointerUnitChecker.sv
test/pointerUnit_assert.sv
test/pointerUnitTb.sv

//--- run.sh
#!/bin/sh
# Builds the pointer unit testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module pointerUnitTb -f pointerUnit.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -qx "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- test/pointerUnitTb.sv
////////////////////////////////////////
// Pointer unit testbench
////////////////////////////////////////
`include "pointer_settings.svh"

module pointerUnitTb;

    timeunit 1ns;
    timeprecision 1ps;

    import pointerPkg::*;

    localparam int drainLimit = 20;   // Cycles allowed for the last results.
    localparam int lineLimit  = 1000;

    logic               clk = 1'b0;
    logic               arstN;
    logic [`DATA_W-1:0] opIn;
    logic               opLoad;
    pointerMode_t       mode;
    logic [`DATA_W-1:0] index;
    logic               calc;
    addrResult_t        result;
    logic               addrValid;

    // Reference copy of the two operand registers.
    logic [`DATA_W-1:0] modelOp;
    logic [`DATA_W-1:0] modelOpOld;

    int seed = 42;
    int tbErrors;
    int testCount;

    always #20 clk = ~clk;

    pointerUnit pointerUnit_i (
        .clk       (clk),
        .arstN     (arstN),
        .opIn      (opIn),
        .opLoad    (opLoad),
        .mode      (mode),
        .index     (index),
        .calc      (calc),
        .result    (result),
        .addrValid (addrValid)
    );

    pointerUnitChecker resultChecker (
        .clk       (clk),
        .arstN     (arstN),
        .result    (result),
        .addrValid (addrValid)
    );

    // Effective address from the addressing-mode table.
    function automatic addrResult_t predictResult(input pointerMode_t m,
            input logic [`DATA_W-1:0] curOp, input logic [`DATA_W-1:0] oldOp,
            input logic [`DATA_W-1:0] idx);
        logic [`ADDR_W-1:0] lowWord;
        logic [`DATA_W-1:0] highByte;
        logic [`ADDR_W:0]   total;
        addrResult_t        r;
        lowWord  = '0;
        highByte = '0;
        case (m)
            modePage0, modeIndirect: lowWord = {{`DATA_W{1'b0}}, curOp};
            modeTopPage:             lowWord = {`TOP_PAGE, curOp};
            modeAbsolute:            lowWord = {curOp, oldOp};
            modeOldPage:             lowWord = {{`DATA_W{1'b0}}, oldOp};
            modeOpHigh:              highByte = curOp;
            default:                 lowWord = '0;
        endcase
        total      = {1'b0, lowWord} + {1'b0, highByte, idx};
        r.addr     = total[`ADDR_W-1:0];
        r.carry    = total[`ADDR_W];
        r.indirect = (m == modeIndirect);
        return r;
    endfunction

    task automatic driveIdle();
        opLoad = 1'b0;
        calc   = 1'b0;
        @(negedge clk);
    endtask

    task automatic applyLine(input logic [7:0] kind, input pointerMode_t lineMode,
            input logic [`DATA_W-1:0] opnd, input logic [`DATA_W-1:0] idx,
            input addrResult_t expected, input int lineNo);
        addrResult_t predicted;
        string       testName;
        if (kind != "L" && kind != "C" && kind != "B") begin
            $display("Trace line %0d has an unknown operation", lineNo);
            tbErrors++;
        end
        opLoad = (kind == "L" || kind == "B");
        calc   = (kind == "C" || kind == "B");
        opIn   = opnd;
        mode   = lineMode;
        index  = idx;
        if (calc) begin
            // A load on the same edge does not reach this calc.
            predicted = predictResult(lineMode, modelOp, modelOpOld, idx);
            testName  = $sformatf("line%0d_%s", lineNo, lineMode.name());
            if (predicted != expected) begin
                $display("Trace line %0d disagrees with the reference model", lineNo);
                tbErrors++;
            end
            resultChecker.pushExpected(testName, expected);
            testCount++;
        end
        if (opLoad) begin
            modelOpOld = modelOp;
            modelOp    = opnd;
        end
        @(negedge clk);
    endtask

    initial begin
        int                 fd;
        int                 code;
        int                 lineNo;
        int                 idle;
        int                 gap;
        int                 modeVal;
        int                 carryVal;
        int                 indVal;
        int                 waitCount;
        logic [7:0]         kind;
        logic [`DATA_W-1:0] opnd;
        logic [`DATA_W-1:0] idx;
        logic [`ADDR_W-1:0] addr;
        string              lineStr;
        addrResult_t        expected;

        arstN      = 1'b0;
        opIn       = '0;
        opLoad     = 1'b0;
        mode       = modeNone;
        index      = '0;
        calc       = 1'b0;
        modelOp    = '0;
        modelOpOld = '0;
        tbErrors   = 0;
        testCount  = 0;
        repeat (4) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        fd = $fopen("test/pointerUnit_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file test/pointerUnit_trace.txt");
            tbErrors++;
        end else begin
            lineNo = 0;
            while (!$feof(fd) && lineNo < lineLimit) begin
                code = $fgets(lineStr, fd);
                lineNo++;
                if (code == 0 || lineStr.len() < 2 || lineStr[0] == "#") begin
                    continue;
                end
                code = $sscanf(lineStr, "%d %s %d %h %h %h %d %d", gap, kind, modeVal,
                               opnd, idx, addr, carryVal, indVal);
                if (code != 8) begin
                    $display("Trace line %0d could not be read", lineNo);
                    tbErrors++;
                    continue;
                end
                if (gap != 0) begin
                    idle = $random(seed) & 3;
                    repeat (idle) driveIdle();
                end
                expected.addr     = addr;
                expected.carry    = carryVal[0];
                expected.indirect = indVal[0];
                applyLine(kind, pointerMode_t'(modeVal[2:0]), opnd, idx, expected, lineNo);
            end
            $fclose(fd);
        end
        driveIdle();

        waitCount = 0;
        while (resultChecker.pendingCount() != 0 && waitCount < drainLimit) begin
            @(negedge clk);
            waitCount++;
        end
        if (resultChecker.pendingCount() != 0) begin
            $display("Timed out after %0d cycles with %0d results still missing",
                     waitCount, resultChecker.pendingCount());
            tbErrors++;
        end

        if (pointerUnit_i.uPointerUnitAssert.assertFailures != 0) begin
            $display("Assertions on the pointer unit failed %0d times",
                     pointerUnit_i.uPointerUnitAssert.assertFailures);
            tbErrors++;
        end

        resultChecker.reportCounts();
        if (tbErrors == 0 && resultChecker.failCount == 0 &&
                resultChecker.passCount == testCount) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- test/pointerUnit_assert.sv
////////////////////////////////////////
// Pointer unit assertions
////////////////////////////////////////
module pointerUnitAssert (
    input logic                     clk,
    input logic                     arstN,
    input logic                     calc,
    input pointerPkg::pointerMode_t mode,
    input pointerPkg::paSelect_t    sel,
    input pointerPkg::addrResult_t  result,
    input logic                     addrValid
);

    timeunit 1ns;
    timeprecision 1ps;

    import pointerPkg::*;

    logic [5:0] activeLines;
    int         assertFailures = 0;

    // The pair line is active low, so it is flipped before counting.
    assign activeLines = {sel.opLow, sel.indirectLow, sel.topPageLow,
                          ~sel.notOpOldPair, sel.oldLow, sel.opHigh};

    validAfterCalc: assert property (@(posedge clk) disable iff (!arstN) calc |=> addrValid)
        else begin
            assertFailures++;
            $error("addrValid did not follow calc");
        end

    quietWithoutCalc: assert property (@(posedge clk) disable iff (!arstN) !calc |=> !addrValid)
        else begin
            assertFailures++;
            $error("addrValid rose without a calc");
        end

    atMostOneLine: assert property (@(posedge clk) disable iff (!arstN) $onehot0(activeLines))
        else begin
            assertFailures++;
            $error("More than one select line is active");
        end

    oneLinePerMode: assert property (@(posedge clk) disable iff (!arstN)
        (mode inside {modePage0, modeIndirect, modeTopPage, modeAbsolute, modeOldPage,
                      modeOpHigh}) |-> $onehot(activeLines))
        else begin
            assertFailures++;
            $error("Addressing mode did not raise exactly one select line");
        end

    quietInReset: assert property (@(posedge clk) !arstN |-> (!addrValid && result == '0))
        else begin
            assertFailures++;
            $error("Outputs were not quiet during reset");
        end

endmodule

bind pointerUnit pointerUnitAssert uPointerUnitAssert (
    .clk       (clk),
    .arstN     (arstN),
    .calc      (calc),
    .mode      (mode),
    .sel       (sel),
    .result    (result),
    .addrValid (addrValid)
);

//--- test/pointerUnitChecker.sv
////////////////////////////////////////
// Pointer unit result checker
////////////////////////////////////////
module pointerUnitChecker (
    input logic                    clk,
    input logic                    arstN,
    input pointerPkg::addrResult_t result,
    input logic                    addrValid
);

    timeunit 1ns;
    timeprecision 1ps;

    import pointerPkg::*;

    addrResult_t expQ[$];
    string       nameQ[$];
    addrResult_t expNow;
    string       nameNow;
    int          passCount = 0;
    int          failCount = 0;

    task automatic pushExpected(input string testName, input addrResult_t expected);
        nameQ.push_back(testName);
        expQ.push_back(expected);
    endtask

    function automatic int pendingCount();
        return expQ.size();
    endfunction

    task automatic reportCounts();
        $display("Tests finished: %0d passed, %0d failed, %0d never answered",
                 passCount, failCount, expQ.size());
    endtask

    // Results are registered on the rising edge and hold through the falling one.
    always @(negedge clk) begin
        if (arstN && addrValid) begin
            if (expQ.size() == 0) begin
                $display("addrValid was high but no test was waiting for a result");
                failCount++;
            end else begin
                expNow  = expQ.pop_front();
                nameNow = nameQ.pop_front(); // Names and values travel in step.
                if (result === expNow) begin
                    passCount++;
                    $display("PASS %s addr=%h carry=%b indirect=%b",
                             nameNow, result.addr, result.carry, result.indirect);
                end else begin
                    failCount++;
                    $display("** Error %s: expected addr=%h carry=%b indirect=%b, %s",
                             nameNow, expNow.addr, expNow.carry, expNow.indirect,
                             $sformatf("actual addr=%h carry=%b indirect=%b",
                                       result.addr, result.carry, result.indirect));
                end
            end
        end
    end

endmodule

//--- verilog/pointerUnit.sv
////////////////////////////////////////
// Operand pointer unit
////////////////////////////////////////
`include "pointer_settings.svh"

module pointerUnit (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic [`DATA_W-1:0]       opIn,
    input  logic                     opLoad,
    input  pointerPkg::pointerMode_t mode,
    input  logic [`DATA_W-1:0]       index,
    input  logic                     calc,
    output pointerPkg::addrResult_t  result,
    output logic                     addrValid
);

    import pointerPkg::*;

    logic [`DATA_W-1:0] notOp;
    logic [`DATA_W-1:0] notOpOld;
    paSelect_t          sel;
    logic [`ADDR_W-1:0] low;
    logic [`DATA_W-1:0] high;

    operandLatch uOperandLatch (
        .clk      (clk),
        .arstN    (arstN),
        .opIn     (opIn),
        .opLoad   (opLoad),
        .notOp    (notOp),
        .notOpOld (notOpOld)
    );

    addrModeDecode uAddrModeDecode (
        .mode (mode),
        .sel  (sel)
    );

    aluInputMux uAluInputMux (
        .notOp    (notOp),
        .notOpOld (notOpOld),
        .sel      (sel),
        .low      (low),
        .high     (high)
    );

    // The indirect select line doubles as the result's indirect flag.
    pointerAlu uPointerAlu (
        .clk       (clk),
        .arstN     (arstN),
        .low       (low),
        .high      (high),
        .index     (index),
        .topPage   (sel.topPageLow),
        .indirect  (sel.indirectLow),
        .calc      (calc),
        .result    (result),
        .addrValid (addrValid)
    );

endmodule

//--- verilog/pointerAlu.sv
////////////////////////////////////////
// Effective address adder
////////////////////////////////////////
`include "pointer_settings.svh"

module pointerAlu (
    input  logic              clk,
    input  logic              arstN,
    input  logic [`ADDR_W-1:0] low,
    input  logic [`DATA_W-1:0] high,
    input  logic [`DATA_W-1:0] index,
    input  logic              topPage,
    input  logic              indirect,
    input  logic              calc,
    output pointerPkg::addrResult_t result,
    output logic              addrValid
);

    import pointerPkg::*;

    logic [`ADDR_W-1:0] lowEff;
    logic [`ADDR_W-1:0] highWord;
    logic [`ADDR_W:0]   sum;
    addrResult_t        nextResult;

    // Top-page mode replaces the upper byte of the Low operand.
    assign lowEff = topPage ? {`TOP_PAGE, low[`DATA_W-1:0]} : low;

    assign highWord = {high, index};

    // One extra bit catches the carry out of the address.
    assign sum = {1'b0, lowEff} + {1'b0, highWord};

    always_comb begin
        nextResult.addr     = sum[`ADDR_W-1:0];
        nextResult.carry    = sum[`ADDR_W];
        nextResult.indirect = indirect;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result    <= '0;
            addrValid <= 1'b0;
        end else begin
            addrValid <= calc; // High for the single cycle after calc.
            if (calc) begin
                result <= nextResult;
            end
        end
    end

endmodule

//--- verilog/aluInputMux.sv
////////////////////////////////////////
// ALU input multiplexer
////////////////////////////////////////
`include "pointer_settings.svh"

module aluInputMux (
    input  logic [`DATA_W-1:0] notOp,
    input  logic [`DATA_W-1:0] notOpOld,
    input  pointerPkg::paSelect_t sel,
    output logic [`ADDR_W-1:0] low,
    output logic [`DATA_W-1:0] high
);

    logic              notOpLowGate;
    logic              notOldLowGate;
    logic              notOpHighGate;
    logic [`DATA_W-1:0] lowFromOp;
    logic [`DATA_W-1:0] lowFromOld;
    logic [`DATA_W-1:0] notLowByte;

    // Gates are built as NOR stages, as on the board.
    assign notOpLowGate  = ~(sel.opLow | sel.indirectLow | sel.topPageLow);
    assign notOldLowGate = ~(~sel.notOpOldPair | sel.oldLow);
    assign notOpHighGate = ~(sel.opHigh | sel.opHigh);

    // A NOR of an inverted byte with a low gate passes the true byte.
    assign lowFromOp  = ~(notOp | {`DATA_W{notOpLowGate}});
    assign lowFromOld = ~(notOpOld | {`DATA_W{notOldLowGate}});
    assign notLowByte = ~(lowFromOp | lowFromOld);

    assign low[`DATA_W-1:0]       = ~(notLowByte | notLowByte);
    assign low[`ADDR_W-1:`DATA_W] = ~(notOp | {`DATA_W{sel.notOpOldPair}}); // OP above OpOld.

    assign high = ~(notOp | {`DATA_W{notOpHighGate}});

endmodule

//--- verilog/addrModeDecode.sv
////////////////////////////////////////
// Addressing mode decoder
////////////////////////////////////////
module addrModeDecode (
    input  pointerPkg::pointerMode_t mode,
    output pointerPkg::paSelect_t    sel
);

    import pointerPkg::*;

    // One select line per mode. The OP:OpOld pair is active low.
    always_comb begin
        sel              = '0;
        sel.notOpOldPair = 1'b1;
        case (mode)
            modePage0: begin
                sel.opLow = 1'b1;
            end
            modeIndirect: begin
                sel.indirectLow = 1'b1;
            end
            modeTopPage: begin
                sel.topPageLow = 1'b1;
            end
            modeAbsolute: begin
                sel.notOpOldPair = 1'b0;
            end
            modeOldPage: begin
                sel.oldLow = 1'b1;
            end
            modeOpHigh: begin
                sel.opHigh = 1'b1;
            end
            default: begin
                // modeNone and the spare encoding leave every line idle.
            end
        endcase
    end

endmodule

//--- verilog/operandLatch.sv
////////////////////////////////////////
// Operand byte latch
////////////////////////////////////////
`include "pointer_settings.svh"

module operandLatch (
    input  logic              clk,
    input  logic              arstN,
    input  logic [`DATA_W-1:0] opIn,
    input  logic              opLoad,
    output logic [`DATA_W-1:0] notOp,
    output logic [`DATA_W-1:0] notOpOld
);

    logic [`DATA_W-1:0] op;
    logic [`DATA_W-1:0] opOld;

    // Each load shifts the current byte down into OpOld.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            op    <= '0;
            opOld <= '0;
        end else if (opLoad) begin
            opOld <= op;
            op    <= opIn;
        end
    end

    // The register board hands out inverted copies of both bytes.
    assign notOp    = ~op;
    assign notOpOld = ~opOld; // All ones after reset.

endmodule

//--- verilog/pointerPkg.sv
////////////////////////////////////////
// Operand pointer types
////////////////////////////////////////
`include "pointer_settings.svh"

package pointerPkg;

    // Addressing modes. Encoding 3'd7 is unused and decodes as modeNone.
    typedef enum logic [2:0] {
        modeNone     = 3'd0,
        modePage0    = 3'd1,
        modeIndirect = 3'd2,
        modeTopPage  = 3'd3,
        modeAbsolute = 3'd4,
        modeOldPage  = 3'd5,
        modeOpHigh   = 3'd6
    } pointerMode_t;

    // Select lines of the ALU input multiplexer.
    typedef struct packed {
        logic opLow;         // OP into the low byte.
        logic indirectLow;   // Same path, indirect access.
        logic topPageLow;    // OP into the low byte, top page above.
        logic notOpOldPair;  // Active low. OP:OpOld as a full word.
        logic oldLow;        // OpOld into the low byte.
        logic opHigh;        // OP into the High operand.
    } paSelect_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic               carry;
        logic               indirect;
    } addrResult_t;

endpackage

//--- verilog/pointer_settings.svh
////////////////////////////////////////
// Operand pointer widths and constants
////////////////////////////////////////
`ifndef POINTER_SETTINGS_SVH
`define POINTER_SETTINGS_SVH

// Width of one operand byte on the register board.
`define DATA_W 8

// Width of the effective address bus.
`define ADDR_W 16

// High byte forced in top-page mode.
`define TOP_PAGE 8'hff

`endif
